// ==== sources.f ====
+incdir+.
tlk_tx_pkg.sv
tlk_tx_regs.sv
tlk_tx_fifo.sv
tlk_tx_pattern.sv
tlk_tx_framer.sv
tlk_tx_top.sv
tb_tlk_tx_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the TLK2711 transmit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f sources.f \
    --top-module tb_tlk_tx_top -Mdir obj_dir -o sim_tlk_tx
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tlk_tx
status=$?
if [ $status -ne 0 ]; then
    echo "simulation ended with status $status"
    exit $status
fi
exit 0

// ==== tb_tlk_tx_top.sv ====
// testbench for the TLK2711 transmit path
// row table of register setups, DMA beat feeder, reference line words
`timescale 1ns/1ps
`include "tlk_tx_consts.svh"

module tb_tlk_tx_top
    import tlk_tx_pkg::*;
();

    typedef struct packed {
        tx_mode_e   mode;
        byte_len_t  body_len;
        byte_len_t  tail_len;
        frame_num_t body_num;
        logic       dma_gaps;
        logic [2:0] pins;
    } test_row_t;

    localparam int NUM_ROWS = 6;

    localparam line_word_t SYNC_REF  = '{k_msb: 1'b0, k_lsb: 1'b1, data: {`D5_6, `K28_5}};
    localparam line_word_t KCODE_REF = '{k_msb: 1'b1, k_lsb: 1'b1, data: {`D5_6, `K28_5}};
    localparam line_word_t SOF_REF   = '{k_msb: 1'b1, k_lsb: 1'b1, data: {`K28_2, `K27_7}};
    localparam line_word_t EOF_REF   = '{k_msb: 1'b1, k_lsb: 1'b1, data: {`K29_7, `K30_7}};
    localparam line_word_t COMMA_REF = '{k_msb: 1'b0, k_lsb: 1'b1, data: {`K28_5, `D5_6}};
    localparam line_word_t START_REF = '{k_msb: 1'b0, k_lsb: 1'b1, data: {`K28_5, `D11_5}};

    logic       clk;
    logic       i_soft_reset;
    wb_req_t    wb_req;
    wb_rsp_t    wb_rsp;
    logic       dma_valid;
    dma_beat_t  dma_data;
    logic       dma_ready;
    logic       irq;
    line_word_t tx_line;
    logic       tlk_enable;
    logic       tlk_loopen;
    logic       tlk_lckrefn;

    test_row_t  rows [NUM_ROWS];
    integer     seed;
    logic       saw_full;
    int         fill_words;

    tlk_tx_top i_tlk_tx_top (
        .clk           (clk),
        .i_soft_reset  (i_soft_reset),
        .i_wb          (wb_req),
        .o_wb          (wb_rsp),
        .i_dma_valid   (dma_valid),
        .i_dma_data    (dma_data),
        .o_dma_ready   (dma_ready),
        .o_irq         (irq),
        .o_line        (tx_line),
        .o_tlk_enable  (tlk_enable),
        .o_tlk_loopen  (tlk_loopen),
        .o_tlk_lckrefn (tlk_lckrefn)
    );

    initial clk = 1'b0;

    always #5 clk = ~clk;

    ////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////
    task automatic stop_run();
        $display("Simulation failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_line(input string what, input line_word_t got, input line_word_t exp);
        if (got !== exp)
        begin
            $display("[FAIL] o_line %s: got %h expected %h", what, got, exp);
            stop_run();
        end
    endtask

    task automatic check_reg(input string what, input wb_data_t got, input wb_data_t exp);
        if (got !== exp)
        begin
            $display("[FAIL] o_wb.dat %s: got %h expected %h", what, got, exp);
            stop_run();
        end
    endtask

    task automatic check_pins(input logic [2:0] got, input logic [2:0] exp);
        if (got !== exp)
        begin
            $display("[FAIL] o_tlk_enable/loopen/lckrefn: got %h expected %h", got, exp);
            stop_run();
        end
    endtask

    task automatic compare_irq(input logic exp);
        if (irq !== exp)
        begin
            $display("[FAIL] o_irq: got %h expected %h", irq, exp);
            stop_run();
        end
    endtask

    ////////////////////////////////////////
    // bus and stream drivers
    ////////////////////////////////////////
    task automatic bus_cycle(input logic we, input wb_adr_t adr, input wb_data_t wdat,
                             output wb_data_t rdat);
        int waited;
        waited = 0;
        @(posedge clk);
        #1;
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
        do
        begin
            @(negedge clk);
            waited++;
            if (waited > 16)
            begin
                $display("Wishbone cycle to address %0d got no ack", adr);
                stop_run();
            end
        end
        while (!wb_rsp.ack);
        rdat = wb_rsp.dat;
        // request stays up through the ack edge
        @(posedge clk);
        #1;
        wb_req = '0;
    endtask

    task automatic wb_write(input wb_adr_t adr, input wb_data_t dat);
        wb_data_t unused;
        bus_cycle(1'b1, adr, dat, unused);
    endtask

    task automatic wb_read(input wb_adr_t adr, output wb_data_t dat);
        bus_cycle(1'b0, adr, '0, dat);
    endtask

    // beat k carries four consecutive word values, low half first
    task automatic feed_dma(input int beats, input logic gaps, input line_data_t base);
        int         idle;
        int         waited;
        line_data_t w;
        // with gaps the first beat waits out the sync period so data starts dry
        if (gaps)
        begin
            repeat (`TLK_SYNC_CYCLES + 16) @(posedge clk);
            #1;
        end
        for (int k = 0; k < beats; k++)
        begin
            idle = gaps ? ($random(seed) & 7) : 0;
            if (idle > 0)
            begin
                dma_valid = 1'b0;
                repeat (idle) @(posedge clk);
                #1;
            end
            w = base + 16'(4 * k);
            dma_data  = {w + 16'd3, w + 16'd2, w + 16'd1, w};
            dma_valid = 1'b1;
            waited = 0;
            @(negedge clk);
            while (!dma_ready)
            begin
                saw_full = 1'b1;
                waited++;
                if (waited > 2000)
                begin
                    $display("DMA beat %0d was never accepted", k);
                    stop_run();
                end
                @(negedge clk);
            end
            @(posedge clk);
            #1;
        end
        dma_valid = 1'b0;
    endtask

    ////////////////////////////////////////
    // line checkers
    ////////////////////////////////////////
    task automatic sample_line(output line_word_t w);
        @(negedge clk);
        w = tx_line;
    endtask

    task automatic seek_line(input line_word_t target, input int limit, input string what);
        line_word_t got;
        int         waited;
        waited = 0;
        sample_line(got);
        while (got !== target)
        begin
            waited++;
            if (waited > limit)
            begin
                $display("%s", what);
                stop_run();
            end
            sample_line(got);
        end
    endtask

    task automatic frame_stream(input test_row_t row, input line_data_t base);
        line_word_t got;
        byte_len_t  len;
        int         n;
        int         skipped;
        logic       last;
        n = 0;
        seek_line(SYNC_REF, 100, "sync period never started after the start command");
        for (int i = 1; i < `TLK_SYNC_CYCLES; i++)
        begin
            sample_line(got);
            check_line("sync", got, SYNC_REF);
        end
        for (int f = 0; f <= int'(row.body_num); f++)
        begin
            last = f == int'(row.body_num);
            len  = last ? row.tail_len : row.body_len;
            sample_line(got);
            check_line("start of frame", got, SOF_REF);
            sample_line(got);
            check_line("header low", got, {2'b00, `HEAD_1, `HEAD_0});
            sample_line(got);
            check_line("header high", got, {2'b00, `HEAD_3, `HEAD_2});
            sample_line(got);
            check_line("file sign", got, {2'b00, (last ? `FILE_END : 8'h00), `TX_IND});
            sample_line(got);
            check_line("frame number", got, {2'b00, 16'(f)});
            sample_line(got);
            check_line("valid length", got, {2'b00, len});
            for (int idx = 0; idx < int'(len) / 2; idx++)
            begin
                sample_line(got);
                skipped = 0;
                // fill words while the FIFO is dry
                while (got === SYNC_REF)
                begin
                    fill_words++;
                    skipped++;
                    if (skipped > 500)
                    begin
                        $display("data section stalled on fill words in frame %0d", f);
                        stop_run();
                    end
                    sample_line(got);
                end
                check_line("data", got, {2'b00, base + 16'(n)});
                n++;
            end
            sample_line(got);
            check_line("check word", got, {2'b00, 16'((int'(len) / 2 + 3) * 2)});
            sample_line(got);
            check_line("end of frame", got, EOF_REF);
            for (int i = 0; i < `TLK_GAP_CYCLES; i++)
            begin
                sample_line(got);
                check_line("gap", got, SYNC_REF);
            end
        end
        sample_line(got);
        check_line("idle after last gap", got, '0);
    endtask

    task automatic kcode_words();
        line_word_t got;
        seek_line(KCODE_REF, 20, "K-code word never appeared");
        for (int i = 0; i < 32; i++)
        begin
            sample_line(got);
            check_line("K-code", got, KCODE_REF);
        end
    endtask

    task automatic pattern_words();
        line_word_t got;
        seek_line(COMMA_REF, 20, "pattern comma word never appeared");
        sample_line(got);
        check_line("second comma", got, COMMA_REF);
        sample_line(got);
        check_line("pattern start", got, START_REF);
        // runs past 31 to see the wrap
        for (int c = 0; c < 40; c++)
        begin
            sample_line(got);
            check_line("pattern count", got, {2'b00, 3'b000, 5'(c), 3'b000, 5'(c)});
        end
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////
    initial
    begin
        line_data_t base;
        wb_data_t   rdat;
        int         beats;
        int         waited;
        seed         = 32'h95d5_e657;
        i_soft_reset = 1'b1;
        wb_req       = '0;
        dma_valid    = 1'b0;
        dma_data     = '0;
        saw_full     = 1'b0;
        fill_words   = 0;

        // mode, body_len, tail_len, body_num, DMA gaps, {enable, loopen, lckrefn}
        rows[0] = '{MODE_NORM,     16'd64, 16'd24, 16'd2, 1'b0, 3'b101};
        rows[1] = '{MODE_KCODE,    16'd0,  16'd0,  16'd0, 1'b0, 3'b101};
        rows[2] = '{MODE_LOOPBACK, 16'd0,  16'd0,  16'd0, 1'b0, 3'b111};
        rows[3] = '{MODE_NORM,     16'd32, 16'd8,  16'd4, 1'b1, 3'b101};
        rows[4] = '{MODE_TEST,     16'd0,  16'd0,  16'd0, 1'b0, 3'b101};
        rows[5] = '{MODE_NORM,     16'd40, 16'd0,  16'd1, 1'b1, 3'b101};

        repeat (15) @(posedge clk);
        @(negedge clk);
        check_pins({tlk_enable, tlk_loopen, tlk_lckrefn}, 3'b000);
        check_line("reset", tx_line, '0);
        compare_irq(1'b0);
        @(posedge clk);
        #1;
        i_soft_reset = 1'b0;
        // pins follow on the first clock without reset
        @(posedge clk);
        @(negedge clk);
        check_pins({tlk_enable, tlk_loopen, tlk_lckrefn}, 3'b101);
        wb_read(`REG_CTRL, rdat);
        check_reg("ctrl after reset", rdat, 32'h0);
        wb_read(`REG_STATUS, rdat);
        check_reg("status after reset", rdat, 32'h0);

        for (int r = 0; r < NUM_ROWS; r++)
        begin
            base = 16'(r) << 12;
            wb_write(`REG_BODY_LEN, {16'd0, rows[r].body_len});
            wb_write(`REG_TAIL_LEN, {16'd0, rows[r].tail_len});
            wb_write(`REG_BODY_NUM, {16'd0, rows[r].body_num});
            wb_write(`REG_CTRL, {27'd0, 1'b1, rows[r].mode});
            if (rows[r].mode == MODE_NORM)
            begin
                beats = (rows[r].body_num * rows[r].body_len + rows[r].tail_len) / 8;
                saw_full = 1'b0;
                fork
                    feed_dma(beats, rows[r].dma_gaps, base);
                    frame_stream(rows[r], base);
                    begin
                        wb_read(`REG_STATUS, rdat);
                        check_reg("status while running", rdat, 32'h2);
                    end
                join
                if (!rows[r].dma_gaps && beats > `TLK_FIFO_DEPTH && !saw_full)
                begin
                    $display("DMA ready never dropped although the FIFO had to fill");
                    stop_run();
                end
                waited = 0;
                @(negedge clk);
                while (!irq)
                begin
                    waited++;
                    if (waited > 20)
                    begin
                        $display("interrupt did not follow the last frame");
                        stop_run();
                    end
                    @(negedge clk);
                end
                wb_read(`REG_STATUS, rdat);
                check_reg("status after run", rdat, 32'h1);
                wb_write(`REG_STATUS, 32'h1);
                @(negedge clk);
                compare_irq(1'b0);
                wb_read(`REG_STATUS, rdat);
                check_reg("status after clear", rdat, 32'h0);
            end
            else if (rows[r].mode == MODE_KCODE)
                kcode_words();
            else
                pattern_words();
            @(negedge clk);
            check_pins({tlk_enable, tlk_loopen, tlk_lckrefn}, rows[r].pins);
            wb_read(`REG_CTRL, rdat);
            check_reg("ctrl mode", rdat, {28'd0, rows[r].mode});
        end

        if (fill_words == 0)
        begin
            $display("no fill word appeared inside a data section");
            stop_run();
        end
        else
        begin
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule

// ==== tlk_tx_top.sv ====
// TLK2711 transmit top: registers, beat FIFO, pattern and framer
`timescale 1ns/1ps

module tlk_tx_top
    import tlk_tx_pkg::*;
(
    input  logic       clk,
    input  logic       i_soft_reset,
    input  wb_req_t    i_wb,
    output wb_rsp_t    o_wb,
    input  logic       i_dma_valid,
    input  dma_beat_t  i_dma_data,
    output logic       o_dma_ready,
    output logic       o_irq,
    output line_word_t o_line,
    output logic       o_tlk_enable,
    output logic       o_tlk_loopen,
    output logic       o_tlk_lckrefn
);

    tx_cfg_t    cfg;
    logic       start;
    logic       busy;
    logic       done;
    logic       pop;
    line_data_t word;
    logic       word_valid;
    logic       pattern_run;
    line_word_t pattern;

    tlk_tx_regs u_regs (
        .clk           (clk),
        .i_soft_reset  (i_soft_reset),
        .i_wb          (i_wb),
        .o_wb          (o_wb),
        .i_busy        (busy),
        .i_done        (done),
        .o_cfg         (cfg),
        .o_start       (start),
        .o_irq         (o_irq),
        .o_tlk_enable  (o_tlk_enable),
        .o_tlk_loopen  (o_tlk_loopen),
        .o_tlk_lckrefn (o_tlk_lckrefn)
    );

    // DMA writes only in normal mode
    tlk_tx_fifo u_fifo (
        .clk          (clk),
        .i_soft_reset (i_soft_reset),
        .i_enable     (cfg.mode == MODE_NORM),
        .i_dma_valid  (i_dma_valid),
        .i_dma_data   (i_dma_data),
        .o_dma_ready  (o_dma_ready),
        .i_pop        (pop),
        .o_word       (word),
        .o_word_valid (word_valid)
    );

    tlk_tx_pattern u_pattern (
        .clk          (clk),
        .i_soft_reset (i_soft_reset),
        .i_run        (pattern_run),
        .o_word       (pattern)
    );

    tlk_tx_framer u_framer (
        .clk           (clk),
        .i_soft_reset  (i_soft_reset),
        .i_cfg         (cfg),
        .i_start       (start),
        .i_word        (word),
        .i_word_valid  (word_valid),
        .o_pop         (pop),
        .i_pattern     (pattern),
        .o_pattern_run (pattern_run),
        .o_line        (o_line),
        .o_busy        (busy),
        .o_done        (done)
    );

endmodule

// ==== tlk_tx_framer.sv ====
// frame FSM with sync, header, data, check word and gap
// output select between frame stream, K-code word and pattern
`timescale 1ns/1ps
`include "tlk_tx_consts.svh"

module tlk_tx_framer
    import tlk_tx_pkg::*;
(
    input  logic       clk,
    input  logic       i_soft_reset,
    input  tx_cfg_t    i_cfg,
    input  logic       i_start,
    input  line_data_t i_word,
    input  logic       i_word_valid,
    output logic       o_pop,
    input  line_word_t i_pattern,
    output logic       o_pattern_run,
    output line_word_t o_line,
    output logic       o_busy,
    output logic       o_done
);

    localparam line_word_t SYNC_WORD  = '{k_msb: 1'b0, k_lsb: 1'b1, data: {`D5_6, `K28_5}};
    localparam line_word_t KCODE_WORD = '{k_msb: 1'b1, k_lsb: 1'b1, data: {`D5_6, `K28_5}};

    framer_state_e state;
    logic [15:0]   sync_cnt;
    logic          head_cnt;
    logic [15:0]   data_cnt;
    logic [15:0]   gap_cnt;
    frame_num_t    frame_cnt;
    byte_len_t     valid_len;
    logic [15:0]   data_words;
    line_data_t    check_word;
    logic          last_frame;
    logic          sync_end;
    logic          gap_end;
    logic          data_end;
    line_word_t    frame_word;

    assign data_words    = {1'b0, valid_len[15:1]};
    assign check_word    = (data_words + 16'd3) << 1;
    assign last_frame    = frame_cnt == i_cfg.body_num;
    assign sync_end      = sync_cnt == 16'(`TLK_SYNC_CYCLES - 1);
    assign gap_end       = gap_cnt == 16'(`TLK_GAP_CYCLES - 1);
    assign o_pop         = (state == ST_VLD_DATA) & i_word_valid;
    assign data_end      = o_pop & (data_cnt == data_words - 16'd1);
    assign o_busy        = state != ST_IDLE;
    assign o_pattern_run = (i_cfg.mode == MODE_LOOPBACK) | (i_cfg.mode == MODE_TEST);

    ////////////////////////////////////////
    // state machine
    ////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (i_soft_reset)
            state <= ST_IDLE;
        else
        begin
            case (state)
                ST_IDLE:
                    if (i_start && i_cfg.mode == MODE_NORM)
                        state <= ST_BEGIN;
                ST_BEGIN:       state <= ST_SYNC;
                ST_SYNC:        if (sync_end) state <= ST_START_FRAME;
                ST_START_FRAME: state <= ST_FRAME_HEAD;
                ST_FRAME_HEAD:  if (head_cnt) state <= ST_FILE_SIGN;
                ST_FILE_SIGN:   state <= ST_FRAME_NUM;
                ST_FRAME_NUM:   state <= ST_VLD_DLEN;
                ST_VLD_DLEN:    state <= (data_words == '0) ? ST_FRAME_TAIL : ST_VLD_DATA;
                ST_VLD_DATA:    if (data_end) state <= ST_FRAME_TAIL;
                ST_FRAME_TAIL:  state <= ST_END_FRAME;
                ST_END_FRAME:   state <= ST_GAP;
                ST_GAP:
                    if (gap_end)
                        state <= last_frame ? ST_IDLE : ST_START_FRAME;
                default:        state <= ST_IDLE;
            endcase
        end
    end

    ////////////////////////////////////////
    // counters
    ////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (i_soft_reset)
        begin
            sync_cnt  <= '0;
            frame_cnt <= '0;
            o_done    <= 1'b0;
        end
        else
        begin
            if (state == ST_BEGIN)
                sync_cnt <= '0;
            else if (state == ST_SYNC)
                sync_cnt <= sync_cnt + 16'd1;
            // frame index moves on when the gap ends
            if (state == ST_BEGIN)
                frame_cnt <= '0;
            else if (state == ST_GAP && gap_end)
                frame_cnt <= frame_cnt + 16'd1;
            o_done <= (state == ST_GAP) & gap_end & last_frame;
        end
    end

    always_ff @(posedge clk)
    begin
        if (i_soft_reset)
        begin
            head_cnt  <= 1'b0;
            data_cnt  <= '0;
            gap_cnt   <= '0;
            valid_len <= '0;
        end
        else if (state == ST_START_FRAME)
        begin
            head_cnt  <= 1'b0;
            data_cnt  <= '0;
            gap_cnt   <= '0;
            valid_len <= last_frame ? i_cfg.tail_len : i_cfg.body_len;
        end
        else
        begin
            if (state == ST_FRAME_HEAD)
                head_cnt <= ~head_cnt;
            if (o_pop)
                data_cnt <= data_cnt + 16'd1;
            if (state == ST_GAP)
                gap_cnt <= gap_cnt + 16'd1;
        end
    end

    ////////////////////////////////////////
    // line word
    ////////////////////////////////////////
    always_comb
    begin
        frame_word = '0;
        case (state)
            ST_SYNC, ST_GAP:
                frame_word = SYNC_WORD;
            ST_START_FRAME:
                frame_word = '{k_msb: 1'b1, k_lsb: 1'b1, data: {`K28_2, `K27_7}};
            ST_FRAME_HEAD:
                frame_word.data = head_cnt ? {`HEAD_3, `HEAD_2} : {`HEAD_1, `HEAD_0};
            ST_FILE_SIGN:
                frame_word.data = {last_frame ? `FILE_END : 8'h00, `TX_IND};
            ST_FRAME_NUM:
                frame_word.data = frame_cnt;
            ST_VLD_DLEN:
                frame_word.data = valid_len;
            ST_VLD_DATA:
            begin
                // fill word while the FIFO runs dry
                if (i_word_valid)
                    frame_word.data = i_word;
                else
                    frame_word = SYNC_WORD;
            end
            ST_FRAME_TAIL:
                frame_word.data = check_word;
            ST_END_FRAME:
                frame_word = '{k_msb: 1'b1, k_lsb: 1'b1, data: {`K29_7, `K30_7}};
            default: ;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (i_soft_reset)
            o_line <= '0;
        else
        begin
            case (i_cfg.mode)
                MODE_KCODE:               o_line <= KCODE_WORD;
                MODE_LOOPBACK, MODE_TEST: o_line <= i_pattern;
                default:                  o_line <= frame_word;
            endcase
        end
    end

endmodule

// ==== tlk_tx_pattern.sv ====
// comma, start and counting pattern for loopback and test modes
`timescale 1ns/1ps
`include "tlk_tx_consts.svh"

module tlk_tx_pattern
    import tlk_tx_pkg::*;
(
    input  logic       clk,
    input  logic       i_soft_reset,
    input  logic       i_run,
    output line_word_t o_word
);

    typedef enum logic [1:0] {
        PAT_COMMA0,
        PAT_COMMA1,
        PAT_START,
        PAT_COUNT
    } pat_phase_e;

    pat_phase_e phase;
    logic [4:0] count;

    always_ff @(posedge clk)
    begin
        if (i_soft_reset || !i_run)
        begin
            phase <= PAT_COMMA0;
            count <= '0;
        end
        else
        begin
            case (phase)
                PAT_COMMA0: phase <= PAT_COMMA1;
                PAT_COMMA1: phase <= PAT_START;
                PAT_START:  phase <= PAT_COUNT;
                // 5-bit count wraps after 31
                default:    count <= count + 1'b1;
            endcase
        end
    end

    always_comb
    begin
        o_word.k_msb = 1'b0;
        o_word.k_lsb = 1'b1;
        o_word.data  = {`K28_5, `D5_6};
        case (phase)
            PAT_START:
                o_word.data = {`K28_5, `D11_5};
            PAT_COUNT:
            begin
                o_word.k_lsb = 1'b0;
                o_word.data  = {2{3'b000, count}};
            end
            default: ;
        endcase
    end

endmodule

// ==== tlk_tx_fifo.sv ====
// FWFT buffer of 64-bit DMA beats, read out as 16-bit words
`timescale 1ns/1ps
`include "tlk_tx_consts.svh"

module tlk_tx_fifo
    import tlk_tx_pkg::*;
(
    input  logic       clk,
    input  logic       i_soft_reset,
    input  logic       i_enable,
    input  logic       i_dma_valid,
    input  dma_beat_t  i_dma_data,
    output logic       o_dma_ready,
    input  logic       i_pop,
    output line_data_t o_word,
    output logic       o_word_valid
);

    localparam int AW = $clog2(`TLK_FIFO_DEPTH);
    localparam logic [AW:0] FULL_COUNT = `TLK_FIFO_DEPTH;

    dma_beat_t     mem [`TLK_FIFO_DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic [1:0]    half;
    logic          push;
    logic          pop_word;
    logic          beat_done;

    assign o_dma_ready  = i_enable & (count != FULL_COUNT);
    assign push         = i_dma_valid & o_dma_ready;
    assign o_word_valid = count != '0;
    assign pop_word     = i_pop & o_word_valid;
    assign beat_done    = pop_word & (half == 2'd3);

    // low half first
    assign o_word = mem[rd_ptr][{half, 4'b0000} +: 16];

    always_ff @(posedge clk)
    begin
        if (push)
            mem[wr_ptr] <= i_dma_data;
    end

    always_ff @(posedge clk)
    begin
        if (i_soft_reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            half   <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop_word)
                half <= half + 1'b1;
            if (beat_done)
                rd_ptr <= rd_ptr + 1'b1;
            case ({push, beat_done})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

endmodule

// ==== tlk_tx_regs.sv ====
// Wishbone classic register block, start pulse, sticky done
// and TLK2711 pin levels decoded from the mode
`timescale 1ns/1ps
`include "tlk_tx_consts.svh"

module tlk_tx_regs
    import tlk_tx_pkg::*;
(
    input  logic    clk,
    input  logic    i_soft_reset,
    input  wb_req_t i_wb,
    output wb_rsp_t o_wb,
    input  logic    i_busy,
    input  logic    i_done,
    output tx_cfg_t o_cfg,
    output logic    o_start,
    output logic    o_irq,
    output logic    o_tlk_enable,
    output logic    o_tlk_loopen,
    output logic    o_tlk_lckrefn
);

    tx_cfg_t  cfg;
    logic     wb_ack;
    wb_data_t wb_dat;
    logic     wb_wr;
    logic     done;

    // request is still held on the ack cycle
    assign wb_wr = wb_ack & i_wb.we;

    assign o_wb.ack = wb_ack;
    assign o_wb.dat = wb_dat;
    assign o_cfg    = cfg;
    assign o_irq    = done;

    always_ff @(posedge clk)
    begin
        if (i_soft_reset)
            wb_ack <= 1'b0;
        else
            wb_ack <= i_wb.cyc & i_wb.stb & ~wb_ack;
    end

    always_ff @(posedge clk)
    begin
        case (i_wb.adr)
            `REG_CTRL:     wb_dat <= {28'd0, cfg.mode};
            `REG_BODY_LEN: wb_dat <= {16'd0, cfg.body_len};
            `REG_TAIL_LEN: wb_dat <= {16'd0, cfg.tail_len};
            `REG_BODY_NUM: wb_dat <= {16'd0, cfg.body_num};
            `REG_STATUS:   wb_dat <= {30'd0, i_busy, done};
            default:       wb_dat <= '0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (i_soft_reset)
        begin
            cfg     <= '{mode: MODE_NORM, default: '0};
            o_start <= 1'b0;
        end
        else
        begin
            // pulse lines up with the new mode
            o_start <= wb_wr & (i_wb.adr == `REG_CTRL) & i_wb.dat[4];
            if (wb_wr)
            begin
                case (i_wb.adr)
                    `REG_CTRL:     cfg.mode     <= tx_mode_e'(i_wb.dat[3:0]);
                    `REG_BODY_LEN: cfg.body_len <= i_wb.dat[15:0];
                    `REG_TAIL_LEN: cfg.tail_len <= i_wb.dat[15:0];
                    `REG_BODY_NUM: cfg.body_num <= i_wb.dat[15:0];
                    default: ;
                endcase
            end
        end
    end

    // set wins over a same-cycle clear
    always_ff @(posedge clk)
    begin
        if (i_soft_reset)
            done <= 1'b0;
        else if (i_done)
            done <= 1'b1;
        else if (wb_wr && i_wb.adr == `REG_STATUS && i_wb.dat[0])
            done <= 1'b0;
    end

    always_ff @(posedge clk)
    begin
        if (i_soft_reset)
        begin
            o_tlk_enable  <= 1'b0;
            o_tlk_loopen  <= 1'b0;
            o_tlk_lckrefn <= 1'b0;
        end
        else
        begin
            o_tlk_enable  <= 1'b1;
            o_tlk_loopen  <= cfg.mode == MODE_LOOPBACK;
            o_tlk_lckrefn <= 1'b1;
        end
    end

endmodule

// ==== tlk_tx_pkg.sv ====
// line word, Wishbone and configuration structs
// width typedefs, mode and framer state enums
package tlk_tx_pkg;

    typedef logic [15:0] line_data_t;
    typedef logic [15:0] byte_len_t;
    typedef logic [15:0] frame_num_t;
    typedef logic [63:0] dma_beat_t;
    typedef logic [2:0]  wb_adr_t;
    typedef logic [31:0] wb_data_t;

    typedef enum logic [3:0] {
        MODE_NORM     = 4'd0,
        MODE_LOOPBACK = 4'd1,
        MODE_KCODE    = 4'd2,
        MODE_TEST     = 4'd3
    } tx_mode_e;

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_BEGIN,
        ST_SYNC,
        ST_START_FRAME,
        ST_FRAME_HEAD,
        ST_FILE_SIGN,
        ST_FRAME_NUM,
        ST_VLD_DLEN,
        ST_VLD_DATA,
        ST_FRAME_TAIL,
        ST_END_FRAME,
        ST_GAP
    } framer_state_e;

    // one word on the TLK2711 transmit pins
    typedef struct packed {
        logic       k_msb;
        logic       k_lsb;
        line_data_t data;
    } line_word_t;

    typedef struct packed {
        tx_mode_e   mode;
        byte_len_t  body_len;
        byte_len_t  tail_len;
        frame_num_t body_num;
    } tx_cfg_t;

    typedef struct packed {
        logic     cyc;
        logic     stb;
        logic     we;
        wb_adr_t  adr;
        wb_data_t dat;
    } wb_req_t;

    typedef struct packed {
        logic     ack;
        wb_data_t dat;
    } wb_rsp_t;

endpackage

// ==== tlk_tx_consts.svh ====
// K-codes, frame header and file-sign bytes, register map
// FIFO depth and link timing for the transmit path
`ifndef TLK_TX_CONSTS_SVH
`define TLK_TX_CONSTS_SVH

// 8b/10b control and data codes
`define K28_5 8'hBC
`define D5_6  8'hC5
`define D11_5 8'hAB
`define K27_7 8'hFB
`define K28_2 8'h5C
`define K30_7 8'hFE
`define K29_7 8'hFD

// frame header bytes, sent low byte first
`define HEAD_0 8'h16
`define HEAD_1 8'hE1
`define HEAD_2 8'h90
`define HEAD_3 8'hEB

// file sign
`define TX_IND   8'h81
`define FILE_END 8'h01

// sync and inter-frame gap, short for simulation
`define TLK_SYNC_CYCLES 64
`define TLK_GAP_CYCLES  16

// beats of 64 bits, power of two
`define TLK_FIFO_DEPTH 16

// register addresses
`define REG_CTRL     3'd0
`define REG_BODY_LEN 3'd1
`define REG_TAIL_LEN 3'd2
`define REG_BODY_NUM 3'd3
`define REG_STATUS   3'd4

`endif
